/* Bender.yml */
package:
  name: axi_mem_slave

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/axi_bus_pkg.sv
      - verilog/mem_op_pkg.sv
      - verilog/access_wait_timer.sv
      - verilog/strobe_mem_array.sv
      - verilog/axi_txn_ctrl.sv
      - verilog/axi_mem_slave.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/axi_mem_slave_tb.sv

/* tests/axi_mem_slave_tb.sv */
`include "mem_slave_params.svh"

module axi_mem_slave_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import axi_bus_pkg::*;

  // memory window as seen on the bus
  localparam logic [`MS_ADDR_W-1:0] WIN_BASE = `MS_MEM_BASE;
  localparam logic [`MS_ADDR_W-1:0] WIN_END  = `MS_MEM_BASE + `MS_MEM_WORDS * `MS_STRB_W;
  // rising edges from a W or AR handshake to the response valid
  localparam int unsigned RESP_LAT = `MS_WAIT_CYCLES + 1;
  // roughly 230 transactions of up to 12 cycles plus margin
  localparam int unsigned TIMEOUT_CYCLES = 4000;
  // readies are combinational on inputs so sample them a little after driving
  localparam time SETTLE = 1ns;

  logic                  clock;
  logic                  reset_n;
  logic                  ar_valid_i;
  logic                  ar_ready_o;
  logic [`MS_ADDR_W-1:0] ar_addr_i;
  logic [`MS_ID_W-1:0]   ar_id_i;
  logic                  r_valid_o;
  logic                  r_ready_i;
  logic [`MS_DATA_W-1:0] r_data_o;
  axi_resp_e             r_resp_o;
  logic [`MS_ID_W-1:0]   r_id_o;
  logic                  r_last_o;
  logic                  aw_valid_i;
  logic                  aw_ready_o;
  logic [`MS_ADDR_W-1:0] aw_addr_i;
  logic [`MS_ID_W-1:0]   aw_id_i;
  logic                  w_valid_i;
  logic                  w_ready_o;
  logic [`MS_DATA_W-1:0] w_data_i;
  logic [`MS_STRB_W-1:0] w_strb_i;
  logic                  w_last_i;
  logic                  b_valid_o;
  logic                  b_ready_i;
  axi_resp_e             b_resp_o;
  logic [`MS_ID_W-1:0]   b_id_o;

  int          err_cnt   = 0;
  int          check_cnt = 0;
  int unsigned cycle_cnt = 0;
  logic [31:0] lcg_state = 32'h88799d91;
  // expected memory contents keyed by word index
  logic [`MS_DATA_W-1:0] shadow [int unsigned];

  axi_mem_slave dut_i (.*);

  // 20 ns clock
  always #10 clock = ~clock;

  // edge counter that also sets the run limit
  always @(posedge clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      err_cnt = err_cnt + 1;
      finish_run();
    end
  end

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  task automatic check_eq(input string name, input logic [63:0] exp_v,
                          input logic [63:0] act_v);
    check_cnt++;
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERROR %s: expected %h, actual %h (cycle %0d)", name, exp_v, act_v, cycle_cnt);
    end
  endtask

  // LCG with numerical recipes constants
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // stall of 0 to 7 cycles from the upper bits
  function automatic int rand_delay();
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:29]);
  endfunction

  function automatic bit in_window(input logic [`MS_ADDR_W-1:0] addr);
    return (addr >= WIN_BASE) && (addr < WIN_END);
  endfunction

  function automatic int unsigned word_index(input logic [`MS_ADDR_W-1:0] addr);
    return (addr - WIN_BASE) / `MS_STRB_W;
  endfunction

  function automatic bit has_word(input logic [`MS_ADDR_W-1:0] addr);
    return in_window(addr) && shadow.exists(word_index(addr));
  endfunction

  // byte merge that drops out-of-window writes
  task automatic model_write(input logic [`MS_ADDR_W-1:0] addr,
                             input logic [`MS_DATA_W-1:0] data,
                             input logic [`MS_STRB_W-1:0] strb);
    logic [`MS_DATA_W-1:0] word;
    word = '0;
    if (in_window(addr)) begin
      if (shadow.exists(word_index(addr))) begin
        word = shadow[word_index(addr)];
      end
      for (int b = 0; b < `MS_STRB_W; b++) begin
        if (strb[b]) begin
          word[8*b +: 8] = data[8*b +: 8];
        end
      end
      shadow[word_index(addr)] = word;
    end
  endtask

  // entered and left just after a falling edge
  task automatic axi_write(input  logic [`MS_ADDR_W-1:0] addr,
                           input  logic [`MS_DATA_W-1:0] data,
                           input  logic [`MS_STRB_W-1:0] strb,
                           input  logic [`MS_ID_W-1:0]   id,
                           input  int                    b_delay,
                           output logic [1:0]            resp,
                           output logic [`MS_ID_W-1:0]   bid);
    int unsigned hs_cnt;
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    #(SETTLE);
    while (!aw_ready_o) begin
      @(negedge clock);
      #(SETTLE);
    end
    // a pending write address blocks reads
    check_eq("ar_ready_o", 1'b0, ar_ready_o);
    // AW taken on the rising edge in between
    @(negedge clock);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b1;
    w_data_i   = data;
    w_strb_i   = strb;
    w_last_i   = 1'b1;
    #(SETTLE);
    while (!w_ready_o) begin
      @(negedge clock);
      #(SETTLE);
    end
    @(negedge clock);
    hs_cnt    = cycle_cnt;
    w_valid_i = 1'b0;
    w_last_i  = 1'b0;
    while (!b_valid_o) begin
      @(negedge clock);
    end
    check_eq("b_valid_o latency", RESP_LAT, cycle_cnt - hs_cnt);
    resp = b_resp_o;
    bid  = b_id_o;
    // payload must hold while the master stalls B
    for (int i = 0; i < b_delay; i++) begin
      @(negedge clock);
      check_eq("b_valid_o", 1'b1, b_valid_o);
      check_eq("b_resp_o", resp, b_resp_o);
      check_eq("b_id_o", bid, b_id_o);
      check_eq("ar_ready_o", 1'b0, ar_ready_o);
      check_eq("aw_ready_o", 1'b0, aw_ready_o);
    end
    b_ready_i = 1'b1;
    @(negedge clock);
    b_ready_i = 1'b0;
    check_eq("b_valid_o", 1'b0, b_valid_o);
    check_eq("aw_ready_o", 1'b1, aw_ready_o);
  endtask

  task automatic axi_read(input  logic [`MS_ADDR_W-1:0] addr,
                          input  logic [`MS_ID_W-1:0]   id,
                          input  int                    r_delay,
                          output logic [`MS_DATA_W-1:0] data,
                          output logic [1:0]            resp,
                          output logic [`MS_ID_W-1:0]   rid,
                          output logic                  last);
    int unsigned hs_cnt;
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = id;
    #(SETTLE);
    while (!ar_ready_o) begin
      @(negedge clock);
      #(SETTLE);
    end
    @(negedge clock);
    hs_cnt     = cycle_cnt;
    ar_valid_i = 1'b0;
    while (!r_valid_o) begin
      @(negedge clock);
    end
    check_eq("r_valid_o latency", RESP_LAT, cycle_cnt - hs_cnt);
    data = r_data_o;
    resp = r_resp_o;
    rid  = r_id_o;
    last = r_last_o;
    for (int i = 0; i < r_delay; i++) begin
      @(negedge clock);
      check_eq("r_valid_o", 1'b1, r_valid_o);
      check_eq("r_data_o", data, r_data_o);
      check_eq("r_resp_o", resp, r_resp_o);
      check_eq("r_id_o", rid, r_id_o);
      check_eq("ar_ready_o", 1'b0, ar_ready_o);
      check_eq("aw_ready_o", 1'b0, aw_ready_o);
    end
    r_ready_i = 1'b1;
    @(negedge clock);
    r_ready_i = 1'b0;
    check_eq("r_valid_o", 1'b0, r_valid_o);
  endtask

  task automatic write_check(input logic [`MS_ADDR_W-1:0] addr,
                             input logic [`MS_DATA_W-1:0] data,
                             input logic [`MS_STRB_W-1:0] strb,
                             input logic [`MS_ID_W-1:0]   id,
                             input int                    b_delay);
    logic [1:0]          resp;
    logic [`MS_ID_W-1:0] bid;
    axi_write(addr, data, strb, id, b_delay, resp, bid);
    check_eq("b_resp_o", in_window(addr) ? OKAY : SLVERR, resp);
    check_eq("b_id_o", id, bid);
    model_write(addr, data, strb);
  endtask

  task automatic read_check(input logic [`MS_ADDR_W-1:0] addr,
                            input logic [`MS_ID_W-1:0]   id,
                            input int                    r_delay);
    logic [`MS_DATA_W-1:0] data;
    logic [`MS_DATA_W-1:0] exp_data;
    logic [1:0]            resp;
    logic [`MS_ID_W-1:0]   rid;
    logic                  last;
    // a miss reads as zero
    exp_data = '0;
    if (has_word(addr)) begin
      exp_data = shadow[word_index(addr)];
    end else if (in_window(addr)) begin
      err_cnt++;
      $display("read of address %h has no expected data, the word was never written", addr);
    end
    axi_read(addr, id, r_delay, data, resp, rid, last);
    check_eq("r_data_o", exp_data, data);
    check_eq("r_resp_o", in_window(addr) ? OKAY : SLVERR, resp);
    check_eq("r_id_o", id, rid);
    check_eq("r_last_o", 1'b1, last);
  endtask

  // both address channels raised in the same cycle
  task automatic write_then_read(input logic [`MS_ADDR_W-1:0] addr,
                                 input logic [`MS_DATA_W-1:0] data,
                                 input logic [`MS_STRB_W-1:0] strb,
                                 input logic [`MS_ID_W-1:0]   wid,
                                 input logic [`MS_ID_W-1:0]   rid);
    ar_valid_i = 1'b1;
    ar_addr_i  = addr;
    ar_id_i    = rid;
    // AR stays pending so the read data must already hold the write
    write_check(addr, data, strb, wid, 0);
    read_check(addr, rid, 0);
  endtask

  task automatic test_reset_and_basic();
    check_eq("r_valid_o", 1'b0, r_valid_o);
    check_eq("b_valid_o", 1'b0, b_valid_o);
    check_eq("w_ready_o", 1'b0, w_ready_o);
    check_eq("ar_ready_o", 1'b1, ar_ready_o);
    check_eq("aw_ready_o", 1'b1, aw_ready_o);
    write_check(WIN_BASE + 32'h10, 64'h0123_4567_89ab_cdef, 8'hff, 4'h5, 0);
    read_check(WIN_BASE + 32'h10, 4'ha, 0);
  endtask

  task automatic test_partial_strobes();
    logic [`MS_STRB_W-1:0] strbs [6];
    logic [`MS_ADDR_W-1:0] addr;
    strbs = '{8'h01, 8'h80, 8'h0f, 8'ha5, 8'h3c, 8'h00};
    addr  = WIN_BASE + 32'h40;
    write_check(addr, 64'hffff_ffff_ffff_ffff, 8'hff, 4'h1, 0);
    for (int i = 0; i < 6; i++) begin
      write_check(addr, {next_rand(), next_rand()}, strbs[i], `MS_ID_W'(i), 0);
      read_check(addr, `MS_ID_W'(i + 8), 0);
    end
  endtask

  task automatic test_out_of_range();
    // first word past the window aliases word 0 in the index bits
    write_check(WIN_BASE, 64'h5a5a_0000_1111_a5a5, 8'hff, 4'h2, 0);
    write_check(WIN_END, 64'hdead_beef_dead_beef, 8'hff, 4'h3, 0);
    read_check(WIN_END, 4'h4, 0);
    read_check(WIN_BASE - 32'h8, 4'h6, 0);
    read_check(WIN_BASE, 4'h7, 0);
  endtask

  // latency itself is timed inside every channel task
  task automatic test_latency();
    write_check(WIN_END - 32'h8, {next_rand(), next_rand()}, 8'hff, 4'hc, 0);
    read_check(WIN_END - 32'h8, 4'hd, 0);
    read_check(WIN_BASE + 32'h10, 4'he, 0);
  endtask

  task automatic test_back_pressure();
    logic [`MS_ADDR_W-1:0] addr;
    for (int i = 0; i < 8; i++) begin
      addr = WIN_BASE + 32'h100 + 32'(i * `MS_STRB_W);
      write_check(addr, {next_rand(), next_rand()}, 8'hff, `MS_ID_W'(i), rand_delay());
      read_check(addr, `MS_ID_W'(15 - i), rand_delay());
    end
  endtask

  task automatic test_random_traffic();
    logic [31:0]           r;
    logic [`MS_ADDR_W-1:0] addr;
    logic [`MS_DATA_W-1:0] data;
    logic [`MS_STRB_W-1:0] strb;
    logic [`MS_ID_W-1:0]   id;
    for (int n = 0; n < 100; n++) begin
      r    = next_rand();
      // 32 words starting at offset 400 hex
      addr = WIN_BASE + 32'h400 + 32'(r[14:10]) * `MS_STRB_W;
      id   = r[27:24];
      data = {next_rand(), next_rand()};
      strb = `MS_STRB_W'(next_rand() >> 24);
      // unwritten words get a full write first since the array has no reset
      if (!has_word(addr)) begin
        strb = 8'hff;
      end
      if (r[21:20] == 2'd3) begin
        write_then_read(addr, data, strb, id, ~id);
      end else if (r[21:20] == 2'd2 && has_word(addr)) begin
        read_check(addr, id, int'(r[30:29]));
      end else begin
        write_check(addr, data, strb, id, int'(r[30:29]));
      end
    end
  endtask

  initial begin
    clock      = 1'b0;
    reset_n    = 1'b0;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    ar_id_i    = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    aw_id_i    = '0;
    w_valid_i  = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_last_i   = 1'b0;
    b_ready_i  = 1'b0;
    // two rising edges in reset
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    test_reset_and_basic();
    test_partial_strobes();
    test_out_of_range();
    test_latency();
    test_back_pressure();
    test_random_traffic();
    finish_run();
  end

endmodule

/* verilog/access_wait_timer.sv */
`include "mem_slave_params.svh"

module access_wait_timer #(
  parameter int WAIT_CYCLES = `MS_WAIT_CYCLES
) (
  input  logic clock,
  input  logic reset_n,
  input  logic start_i,
  output logic done_o,
  output logic busy_o
);

  // wide enough to hold WAIT_CYCLES itself
  localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // down-counter, zero means idle
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= CNT_W'(WAIT_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // counting, including the done cycle
  assign busy_o = (cnt_q != '0);

  // last count, one cycle wide
  // sampled WAIT_CYCLES edges after start was taken
  assign done_o = (cnt_q == CNT_W'(1));

  // a restart would stretch the running wait
  a_no_restart: assert property (@(posedge clock) disable iff (!reset_n)
    start_i |-> !busy_o);

endmodule

/* verilog/axi_bus_pkg.sv */
package axi_bus_pkg;

  // controller states
  // one transaction at a time, reads and writes share the sequence
  typedef enum logic [2:0] {
    // waiting for AW or AR, writes win a tie
    IDLE    = 3'd0,
    // read address taken, latency timer running
    RD_WAIT = 3'd1,
    // read data on R, held until r_ready_i
    RD_RESP = 3'd2,
    // write address taken, waiting for the W beat
    WR_DATA = 3'd3,
    // write data taken, latency timer running
    WR_WAIT = 3'd4,
    // write response on B, held until b_ready_i
    WR_RESP = 3'd5
  } txn_state_e;

  // response codes on R and B
  // only the two codes this slave can return
  typedef enum logic [1:0] {
    // access hit the array
    OKAY   = 2'b00,
    // address outside the window
    SLVERR = 2'b10
  } axi_resp_e;

endpackage

/* verilog/axi_mem_slave.sv */
`include "mem_slave_params.svh"

module axi_mem_slave (
  input  logic                   clock,
  input  logic                   reset_n,
  // read address
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [`MS_ADDR_W-1:0]  ar_addr_i,
  input  logic [`MS_ID_W-1:0]    ar_id_i,
  // read data
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic [`MS_DATA_W-1:0]  r_data_o,
  output axi_bus_pkg::axi_resp_e r_resp_o,
  output logic [`MS_ID_W-1:0]    r_id_o,
  output logic                   r_last_o,
  // write address
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [`MS_ADDR_W-1:0]  aw_addr_i,
  input  logic [`MS_ID_W-1:0]    aw_id_i,
  // write data
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  logic [`MS_DATA_W-1:0]  w_data_i,
  input  logic [`MS_STRB_W-1:0]  w_strb_i,
  input  logic                   w_last_i,
  // write response
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output axi_bus_pkg::axi_resp_e b_resp_o,
  output logic [`MS_ID_W-1:0]    b_id_o
);

  import mem_op_pkg::*;

  // controller to timer
  logic                  timer_start;
  logic                  timer_done;
  logic                  timer_busy;
  // controller to array
  mem_op_e               mem_op;
  logic [`MS_ADDR_W-1:0] mem_addr;
  logic [`MS_DATA_W-1:0] mem_wdata;
  logic [`MS_STRB_W-1:0] mem_wstrb;
  logic                  mem_hit;
  logic [`MS_DATA_W-1:0] mem_rdata;

  // handshakes and sequencing
  axi_txn_ctrl u_ctrl (
    .clock         (clock),
    .reset_n       (reset_n),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_addr_i     (ar_addr_i),
    .ar_id_i       (ar_id_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_data_o      (r_data_o),
    .r_resp_o      (r_resp_o),
    .r_id_o        (r_id_o),
    .r_last_o      (r_last_o),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_addr_i     (aw_addr_i),
    .aw_id_i       (aw_id_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_data_i      (w_data_i),
    .w_strb_i      (w_strb_i),
    .w_last_i      (w_last_i),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_resp_o      (b_resp_o),
    .b_id_o        (b_id_o),
    .timer_start_o (timer_start),
    .timer_done_i  (timer_done),
    .mem_op_o      (mem_op),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_wstrb_o   (mem_wstrb),
    .mem_hit_i     (mem_hit),
    .mem_rdata_i   (mem_rdata)
  );

  // access latency model
  access_wait_timer #(
    .WAIT_CYCLES (`MS_WAIT_CYCLES)
  ) u_timer (
    .clock   (clock),
    .reset_n (reset_n),
    .start_i (timer_start),
    .done_o  (timer_done),
    .busy_o  (timer_busy)
  );

  // backing store
  strobe_mem_array #(
    .WORDS (`MS_MEM_WORDS)
  ) u_array (
    .clock   (clock),
    .op_i    (mem_op),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .wstrb_i (mem_wstrb),
    .hit_o   (mem_hit),
    .rdata_o (mem_rdata)
  );

  // controller never starts a wait while the previous one runs
  a_start_idle: assert property (@(posedge clock) disable iff (!reset_n)
    timer_start |-> !timer_busy);

endmodule

/* verilog/axi_txn_ctrl.sv */
`include "mem_slave_params.svh"

module axi_txn_ctrl (
  input  logic                   clock,
  input  logic                   reset_n,
  // read address channel
  input  logic                   ar_valid_i,
  output logic                   ar_ready_o,
  input  logic [`MS_ADDR_W-1:0]  ar_addr_i,
  input  logic [`MS_ID_W-1:0]    ar_id_i,
  // read data channel
  output logic                   r_valid_o,
  input  logic                   r_ready_i,
  output logic [`MS_DATA_W-1:0]  r_data_o,
  output axi_bus_pkg::axi_resp_e r_resp_o,
  output logic [`MS_ID_W-1:0]    r_id_o,
  output logic                   r_last_o,
  // write address channel
  input  logic                   aw_valid_i,
  output logic                   aw_ready_o,
  input  logic [`MS_ADDR_W-1:0]  aw_addr_i,
  input  logic [`MS_ID_W-1:0]    aw_id_i,
  // write data channel
  input  logic                   w_valid_i,
  output logic                   w_ready_o,
  input  logic [`MS_DATA_W-1:0]  w_data_i,
  input  logic [`MS_STRB_W-1:0]  w_strb_i,
  input  logic                   w_last_i,
  // write response channel
  output logic                   b_valid_o,
  input  logic                   b_ready_i,
  output axi_bus_pkg::axi_resp_e b_resp_o,
  output logic [`MS_ID_W-1:0]    b_id_o,
  // latency timer
  output logic                   timer_start_o,
  input  logic                   timer_done_i,
  // memory array port
  output mem_op_pkg::mem_op_e    mem_op_o,
  output logic [`MS_ADDR_W-1:0]  mem_addr_o,
  output logic [`MS_DATA_W-1:0]  mem_wdata_o,
  output logic [`MS_STRB_W-1:0]  mem_wstrb_o,
  input  logic                   mem_hit_i,
  input  logic [`MS_DATA_W-1:0]  mem_rdata_i
);

  import axi_bus_pkg::*;
  import mem_op_pkg::*;

  txn_state_e             state_q;
  logic                   timer_start_q;
  logic [`MS_ADDR_W-1:0]  addr_q;
  logic [`MS_ID_W-1:0]    id_q;
  logic [`MS_DATA_W-1:0]  wdata_q;
  logic [`MS_STRB_W-1:0]  wstrb_q;
  axi_resp_e              resp_q;
  logic                   ar_hs;
  logic                   r_hs;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   b_hs;
  logic                   access_done;

  // ready and valid straight from the state
  assign aw_ready_o = (state_q == IDLE);
  // reads only when no write address is pending
  assign ar_ready_o = (state_q == IDLE) && !aw_valid_i;
  assign w_ready_o  = (state_q == WR_DATA);
  assign r_valid_o  = (state_q == RD_RESP);
  assign b_valid_o  = (state_q == WR_RESP);

  // handshakes
  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  // latency over, array access happens this cycle
  assign access_done = timer_done_i && (state_q == RD_WAIT || state_q == WR_WAIT);

  // state sequence and the timer kick
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state_q       <= IDLE;
      timer_start_q <= 1'b0;
    end else begin
      // start is a single-cycle pulse
      timer_start_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (aw_hs) begin
            state_q <= WR_DATA;
          end else if (ar_hs) begin
            state_q       <= RD_WAIT;
            timer_start_q <= 1'b1;
          end
        end
        RD_WAIT: begin
          if (timer_done_i) begin
            state_q <= RD_RESP;
          end
        end
        RD_RESP: begin
          if (r_hs) begin
            state_q <= IDLE;
          end
        end
        WR_DATA: begin
          // single beat, a missing last still ends the burst
          if (w_hs) begin
            state_q       <= WR_WAIT;
            timer_start_q <= 1'b1;
          end
        end
        WR_WAIT: begin
          if (timer_done_i) begin
            state_q <= WR_RESP;
          end
        end
        WR_RESP: begin
          if (b_hs) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // transaction payload
  always_ff @(posedge clock) begin
    // one address and id register serves both directions
    if (aw_hs) begin
      addr_q <= aw_addr_i;
      id_q   <= aw_id_i;
    end else if (ar_hs) begin
      addr_q <= ar_addr_i;
      id_q   <= ar_id_i;
    end
    if (w_hs) begin
      wdata_q <= w_data_i;
      wstrb_q <= w_strb_i;
    end
    // response follows the range decode at access time
    if (access_done) begin
      resp_q <= mem_hit_i ? OKAY : SLVERR;
    end
  end

  assign timer_start_o = timer_start_q;

  // array opcode, one cycle at the end of the wait
  always_comb begin
    mem_op_o = MEM_NOP;
    if (timer_done_i && state_q == RD_WAIT) begin
      mem_op_o = MEM_READ;
    end else if (timer_done_i && state_q == WR_WAIT && mem_hit_i) begin
      // a miss drops the write
      mem_op_o = MEM_WRITE;
    end
  end

  assign mem_addr_o  = addr_q;
  assign mem_wdata_o = wdata_q;
  assign mem_wstrb_o = wstrb_q;

  // read side, data is the registered array output
  assign r_data_o = mem_rdata_i;
  assign r_resp_o = resp_q;
  assign r_id_o   = id_q;
  // no bursts, every beat is the last
  assign r_last_o = r_valid_o;

  // write response side
  assign b_resp_o = resp_q;
  assign b_id_o   = id_q;

  // only one response channel active at a time
  a_one_resp: assert property (@(posedge clock) disable iff (!reset_n)
    !(r_valid_o && b_valid_o));

  // stalled read keeps valid and data from the array register
  a_r_hold: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_data_o));

  // single-beat writes must carry last
  a_w_last: assert property (@(posedge clock) disable iff (!reset_n)
    w_hs |-> w_last_i);

endmodule

/* verilog/mem_op_pkg.sv */
package mem_op_pkg;

  // array opcodes
  // driven by the controller for a single cycle per access
  typedef enum logic [1:0] {
    // idle, array untouched
    MEM_NOP   = 2'd0,
    // register the addressed word onto the read data
    MEM_READ  = 2'd1,
    // merge the write data into the addressed word by strobe
    MEM_WRITE = 2'd2
  } mem_op_e;

endpackage

/* verilog/mem_slave_params.svh */
`ifndef MEM_SLAVE_PARAMS_SVH
`define MEM_SLAVE_PARAMS_SVH

// bus widths
// address, byte address of the AXI-style channels
`define MS_ADDR_W 32

// data, one 64-bit word per beat
`define MS_DATA_W 64

// one strobe bit per data byte
`define MS_STRB_W 8

// transaction id on AR, AW, R and B
`define MS_ID_W 4

// memory window
// first byte address served by the array
`define MS_MEM_BASE 32'h8000_0000

// depth in 64-bit words, power of two
// 256 words gives a 2 KiB window
`define MS_MEM_WORDS 256

// latency model
// wait cycles between the accepted request and the array access
// must be at least 1
`define MS_WAIT_CYCLES 3

`endif

/* verilog/strobe_mem_array.sv */
`include "mem_slave_params.svh"

module strobe_mem_array #(
  parameter int WORDS = `MS_MEM_WORDS
) (
  input  logic                  clock,
  input  mem_op_pkg::mem_op_e   op_i,
  input  logic [`MS_ADDR_W-1:0] addr_i,
  input  logic [`MS_DATA_W-1:0] wdata_i,
  input  logic [`MS_STRB_W-1:0] wstrb_i,
  output logic                  hit_o,
  output logic [`MS_DATA_W-1:0] rdata_o
);

  import mem_op_pkg::*;

  localparam int ADDR_W = `MS_ADDR_W;
  // byte offset inside a word
  localparam int OFF_W  = $clog2(`MS_STRB_W);
  // word index bits
  localparam int IDX_W  = $clog2(WORDS);
  // window size in bytes
  localparam logic [ADDR_W-1:0] SPAN = ADDR_W'(WORDS * `MS_STRB_W);

  logic [`MS_DATA_W-1:0] mem_q [WORDS];
  logic [ADDR_W-1:0]     offset;
  logic [IDX_W-1:0]      idx;

  // offset from base, addresses below base wrap high and miss
  assign offset = addr_i - `MS_MEM_BASE;
  assign hit_o  = (offset < SPAN);

  // word index, low byte-offset bits ignored
  assign idx = offset[OFF_W +: IDX_W];

  // byte-lane write, untouched lanes keep their value
  always_ff @(posedge clock) begin
    if (op_i == MEM_WRITE) begin
      for (int b = 0; b < `MS_STRB_W; b++) begin
        if (wstrb_i[b]) begin
          mem_q[idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read register
  // updates only on MEM_READ so data holds through R stalls
  always_ff @(posedge clock) begin
    if (op_i == MEM_READ) begin
      if (hit_o) begin
        rdata_o <= mem_q[idx];
      end else begin
        // miss reads as zero
        rdata_o <= '0;
      end
    end
  end

endmodule

/* vlog.f */
+incdir+verilog
verilog/axi_bus_pkg.sv
verilog/mem_op_pkg.sv
verilog/access_wait_timer.sv
verilog/strobe_mem_array.sv
verilog/axi_txn_ctrl.sv
verilog/axi_mem_slave.sv
tests/axi_mem_slave_tb.sv
